/* common/pcie_tx_pkg.sv */
`default_nettype none

package pcie_tx_pkg;

   // which source owns the current packet
   typedef enum logic [1:0]
   {
      kind_none,
      kind_rc,
      kind_rr,
      kind_wr
   } tlp_kind_t;

   typedef struct packed
   {
      tlp_kind_t kind;
      logic      addr_64;   // upper address half nonzero
   } tx_grant_t;

   typedef struct packed
   {
      logic [63:0] data;
      logic        one_dw;  // only data[31:0] carries payload
      logic        last;
   } tx_beat_t;

   // header format/type bytes
   localparam logic [7:0] cpld_fmt     = 8'h4A;
   localparam logic [7:0] mrd_fmt_3dw  = 8'h00;
   localparam logic [7:0] mrd_fmt_4dw  = 8'h20;
   localparam logic [7:0] mwr_fmt_3dw  = 8'h40;
   localparam logic [7:0] mwr_fmt_4dw  = 8'h60;

   localparam int rd_len_dw_default = 128;
   localparam int wr_words_default  = 16;

   // byte reversal of one doubleword, host order to PCIe order
   function automatic logic [31:0] dw_swap(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

`default_nettype wire

/* pcie_tx/pcie_tx_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_arbiter
(
   input  wire logic                   clock,
   input  wire logic                   reset,
   input  wire logic                   rc_valid,
   input  wire logic                   rr_valid,
   input  wire logic                   wr_valid,
   input  wire logic [63:0]            request_addr,
   input  wire logic                   framer_idle,
   output pcie_tx_pkg::tx_grant_t      grant,
   output logic                        grant_valid
);

   pcie_tx_pkg::tlp_kind_t next_kind;
   logic last_rc;   // previous grant went to a completion

   // rc first unless it just had a turn and someone else waits
   always_comb
   begin
      if (rc_valid && !(last_rc && (rr_valid || wr_valid)))
         next_kind = pcie_tx_pkg::kind_rc;
      else if (rr_valid)
         next_kind = pcie_tx_pkg::kind_rr;
      else if (wr_valid)
         next_kind = pcie_tx_pkg::kind_wr;
      else
         next_kind = pcie_tx_pkg::kind_none;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         grant_valid <= 1'b0;
         last_rc     <= 1'b0;
      end
      else
      begin
         grant_valid <= framer_idle && (next_kind != pcie_tx_pkg::kind_none);
         if (framer_idle && (next_kind != pcie_tx_pkg::kind_none))
            last_rc <= (next_kind == pcie_tx_pkg::kind_rc);
      end
   end

   // payload of the grant, sampled once per packet
   always_ff @(posedge clock)
   begin
      if (framer_idle && (next_kind != pcie_tx_pkg::kind_none))
      begin
         grant.kind    <= next_kind;
         grant.addr_64 <= |request_addr[63:32];
      end
   end

   // framer must drop idle as soon as it sees a grant
   a_single_grant : assert property (@(posedge clock) disable iff (reset)
      grant_valid |=> !grant_valid)
      else $error("arbiter issued a second grant back to back");

endmodule

`default_nettype wire

/* pcie_tx/pcie_tx_framer.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_framer
#(
   parameter int RD_LEN_DW = pcie_tx_pkg::rd_len_dw_default,
   parameter int WR_WORDS  = pcie_tx_pkg::wr_words_default
)
(
   input  wire logic                   clock,
   input  wire logic                   reset,
   input  wire logic [15:0]            pcie_id,
   input  wire logic [63:0]            request_addr,
   input  wire logic [23:0]            rc_rid_tag,
   input  wire logic [3:0]             rc_lower_addr,
   input  wire logic [63:0]            rc_data,
   input  wire logic [7:0]             rr_tag,
   input  wire logic                   wr_valid,
   input  wire logic [63:0]            wr_data,
   input  wire pcie_tx_pkg::tx_grant_t grant,
   input  wire logic                   grant_valid,
   input  wire logic                   slice_ready,
   output logic                        framer_idle,
   output logic                        rc_ready,
   output logic                        rr_ready,
   output logic                        wr_ready,
   output pcie_tx_pkg::tx_beat_t       beat,
   output logic                        beat_valid
);

   localparam int CW = $clog2(WR_WORDS + 2);

   logic                   busy;
   pcie_tx_pkg::tlp_kind_t kind_q;
   logic                   addr_64_q;
   logic [CW-1:0]          cnt;        // beat index within the packet
   logic [CW-1:0]          last_cnt;
   logic [CW-1:0]          wr_seen;    // write handshakes this packet
   logic [63:0]            wr_prev;    // word taken on the previous wr beat
   logic                   is_last;
   logic                   wr_beat;
   logic [31:0]            addr_lo;
   logic [31:0]            addr_hi;

   assign addr_lo = request_addr[31:0];
   assign addr_hi = request_addr[63:32];

   always_comb
   begin
      case (kind_q)
         pcie_tx_pkg::kind_rc: last_cnt = CW'(2);
         pcie_tx_pkg::kind_rr: last_cnt = CW'(1);
         default:              last_cnt = CW'(WR_WORDS + 1);
      endcase
   end

   assign is_last = (cnt == last_cnt);
   assign wr_beat = (kind_q == pcie_tx_pkg::kind_wr) && (cnt != '0) && (cnt <= CW'(WR_WORDS));

   // data beats of a write wait for the source word
   assign beat_valid  = busy && (!wr_beat || wr_valid);
   assign framer_idle = !busy && !grant_valid;

   assign rc_ready = busy && slice_ready && (kind_q == pcie_tx_pkg::kind_rc) && is_last;
   assign rr_ready = busy && slice_ready && (kind_q == pcie_tx_pkg::kind_rr) && is_last;
   assign wr_ready = busy && slice_ready && wr_beat && wr_valid;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         busy   <= 1'b0;
         cnt    <= '0;
         kind_q <= pcie_tx_pkg::kind_none;
      end
      else if (grant_valid)
      begin
         busy   <= 1'b1;
         cnt    <= '0;
         kind_q <= grant.kind;
      end
      else if (beat_valid && slice_ready)
      begin
         if (is_last)
            busy <= 1'b0;
         else
            cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (grant_valid)
         addr_64_q <= grant.addr_64;
      if (wr_ready)
         wr_prev <= wr_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset || grant_valid)
         wr_seen <= '0;
      else if (wr_ready)
         wr_seen <= wr_seen + 1'b1;
   end

   always_comb
   begin
      beat      = '0;
      beat.last = is_last;
      case (kind_q)
         pcie_tx_pkg::kind_rc:
         begin
            if (cnt == '0)
               beat.data = {pcie_id, 16'd8, pcie_tx_pkg::cpld_fmt, 24'd2};
            else if (cnt == CW'(1))
               beat.data = {pcie_tx_pkg::dw_swap(rc_data[31:0]), rc_rid_tag,
                            1'b0, rc_lower_addr, 3'd0};
            else
            begin
               beat.data   = {32'h0, pcie_tx_pkg::dw_swap(rc_data[63:32])};
               beat.one_dw = 1'b1;
            end
         end
         pcie_tx_pkg::kind_rr:
         begin
            if (cnt == '0)
               beat.data = {pcie_id, rr_tag, 8'hFF,
                            addr_64_q ? pcie_tx_pkg::mrd_fmt_4dw : pcie_tx_pkg::mrd_fmt_3dw,
                            24'(RD_LEN_DW)};
            else
            begin
               beat.data   = {addr_lo, addr_64_q ? addr_hi : addr_lo};
               beat.one_dw = !addr_64_q;
            end
         end
         pcie_tx_pkg::kind_wr:
         begin
            if (cnt == '0)
               beat.data = {pcie_id, 16'h00FF,
                            addr_64_q ? pcie_tx_pkg::mwr_fmt_4dw : pcie_tx_pkg::mwr_fmt_3dw,
                            24'(2 * WR_WORDS)};
            else if (cnt == CW'(1))   // address beat
               beat.data = addr_64_q ? {addr_lo, addr_hi}
                                     : {pcie_tx_pkg::dw_swap(wr_data[31:0]), addr_lo};
            else if (addr_64_q)       // whole words, one beat late
               beat.data = {pcie_tx_pkg::dw_swap(wr_prev[63:32]),
                            pcie_tx_pkg::dw_swap(wr_prev[31:0])};
            else if (is_last)
            begin
               beat.data   = {32'h0, pcie_tx_pkg::dw_swap(wr_prev[63:32])};
               beat.one_dw = 1'b1;
            end
            else
               beat.data = {pcie_tx_pkg::dw_swap(wr_data[31:0]),
                            pcie_tx_pkg::dw_swap(wr_prev[63:32])};
         end
         default: ;
      endcase
   end

   // arbiter grants only while no packet is in progress
   a_grant_idle : assert property (@(posedge clock) disable iff (reset)
      grant_valid |-> !busy)
      else $error("grant arrived while a packet was in progress");

   a_wr_count : assert property (@(posedge clock) disable iff (reset)
      wr_ready |-> (wr_seen < CW'(WR_WORDS)))
      else $error("too many write words taken in one packet");

endmodule

`default_nettype wire

/* hw/pcie_tx_slice.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_slice
(
   input  wire logic                  clock,
   input  wire logic                  reset,
   input  wire pcie_tx_pkg::tx_beat_t beat,
   input  wire logic                  beat_valid,
   output logic                       slice_ready,
   input  wire logic                  tx_tready,
   output logic [63:0]                tx_tdata,
   output logic                       tx_1dw,
   output logic                       tx_tlast,
   output logic                       tx_tvalid
);

   pcie_tx_pkg::tx_beat_t slot_q [2];
   pcie_tx_pkg::tx_beat_t head;
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            count;    // entries held, 0 to 2
   logic                  push;
   logic                  pop;

   assign push = beat_valid && slice_ready;
   assign pop  = tx_tvalid && tx_tready;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= !wr_ptr;
         if (pop)
            rd_ptr <= !rd_ptr;
         count <= count + 2'(push) - 2'(pop);
      end
   end

   always_ff @(posedge clock)
   begin
      if (push)
         slot_q[wr_ptr] <= beat;
   end

   assign head        = slot_q[rd_ptr];
   assign slice_ready = (count != 2'd2);
   assign tx_tvalid   = (count != 2'd0);
   assign tx_tdata    = head.data;
   assign tx_1dw      = head.one_dw;
   assign tx_tlast    = head.last;

   // stalled beat must hold until the core takes it
   a_hold_stalled : assert property (@(posedge clock) disable iff (reset)
      (tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata)))
      else $error("tx_tdata changed while stalled");

endmodule

`default_nettype wire

/* hw/pcie_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_top
#(
   parameter int RD_LEN_DW = pcie_tx_pkg::rd_len_dw_default,
   parameter int WR_WORDS  = pcie_tx_pkg::wr_words_default
)
(
   input  wire logic        clock,
   input  wire logic        reset,
   input  wire logic [15:0] pcie_id,
   input  wire logic [63:0] request_addr,
   input  wire logic        rc_valid,      // read completion
   input  wire logic [23:0] rc_rid_tag,
   input  wire logic [3:0]  rc_lower_addr,
   input  wire logic [63:0] rc_data,
   output logic             rc_ready,
   input  wire logic        rr_valid,      // read request
   input  wire logic [7:0]  rr_tag,
   output logic             rr_ready,
   input  wire logic        wr_valid,      // write request
   input  wire logic [63:0] wr_data,
   output logic             wr_ready,
   input  wire logic        tx_tready,
   output logic [63:0]      tx_tdata,
   output logic             tx_1dw,
   output logic             tx_tlast,
   output logic             tx_tvalid
);

   pcie_tx_pkg::tx_grant_t grant;
   logic                   grant_valid;
   logic                   framer_idle;
   pcie_tx_pkg::tx_beat_t  beat;
   logic                   beat_valid;
   logic                   slice_ready;

   pcie_tx_arbiter arbiter
   (
      .clock(clock), .reset(reset),
      .rc_valid(rc_valid), .rr_valid(rr_valid), .wr_valid(wr_valid),
      .request_addr(request_addr), .framer_idle(framer_idle),
      .grant(grant), .grant_valid(grant_valid)
   );

   pcie_tx_framer #(.RD_LEN_DW(RD_LEN_DW), .WR_WORDS(WR_WORDS)) framer
   (
      .clock(clock), .reset(reset),
      .pcie_id(pcie_id), .request_addr(request_addr),
      .rc_rid_tag(rc_rid_tag), .rc_lower_addr(rc_lower_addr), .rc_data(rc_data),
      .rr_tag(rr_tag), .wr_valid(wr_valid), .wr_data(wr_data),
      .grant(grant), .grant_valid(grant_valid), .slice_ready(slice_ready),
      .framer_idle(framer_idle),
      .rc_ready(rc_ready), .rr_ready(rr_ready), .wr_ready(wr_ready),
      .beat(beat), .beat_valid(beat_valid)
   );

   pcie_tx_slice slice
   (
      .clock(clock), .reset(reset),
      .beat(beat), .beat_valid(beat_valid), .slice_ready(slice_ready),
      .tx_tready(tx_tready), .tx_tdata(tx_tdata), .tx_1dw(tx_1dw),
      .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid)
   );

endmodule

`default_nettype wire

/* tests/pcie_tx_model.svh */
`ifndef PCIE_TX_MODEL_SVH
`define PCIE_TX_MODEL_SVH

// source handshake records, oldest first
logic [23:0] rc_tag_rec [$];
logic [3:0]  rc_la_rec [$];
logic [63:0] rc_data_rec [$];
logic [7:0]  rr_tag_rec [$];
logic [63:0] wr_word_rec [$];

// expected beats of the packet under check
logic [63:0] exp_data [$];
logic        exp_1dw [$];
logic        exp_last [$];

// host byte order to PCIe byte order
function automatic logic [31:0] reverse_bytes(input logic [31:0] dw);
   logic [31:0] r;
   for (int i = 0; i < 4; i++)
      r[8*i +: 8] = dw[8*(3-i) +: 8];
   return r;
endfunction

function automatic void push_beat(input logic [63:0] d, input logic one, input logic last);
   exp_data.push_back(d);
   exp_1dw.push_back(one);
   exp_last.push_back(last);
endfunction

function automatic void expect_rc(input logic [15:0] id);
   logic [23:0] tag;
   logic [3:0]  la;
   logic [63:0] d;
   tag = rc_tag_rec.pop_front();
   la  = rc_la_rec.pop_front();
   d   = rc_data_rec.pop_front();
   push_beat({id, 16'd8, pcie_tx_pkg::cpld_fmt, 24'd2}, 1'b0, 1'b0);
   push_beat({reverse_bytes(d[31:0]), tag, 1'b0, la, 3'b000}, 1'b0, 1'b0);
   push_beat({32'h0, reverse_bytes(d[63:32])}, 1'b1, 1'b1);
endfunction

function automatic void expect_rr(input logic [15:0] id, input logic [63:0] addr);
   logic [7:0] tag;
   logic       a64;
   tag = rr_tag_rec.pop_front();
   a64 = |addr[63:32];
   push_beat({id, tag, 8'hFF, a64 ? 8'h20 : 8'h00, 24'(RD_LEN)}, 1'b0, 1'b0);
   push_beat({addr[31:0], a64 ? addr[63:32] : addr[31:0]}, !a64, 1'b1);
endfunction

function automatic void expect_wr(input logic [15:0] id, input logic [63:0] addr);
   logic [63:0] w [$];
   logic        a64;
   a64 = |addr[63:32];
   for (int i = 0; i < WR_WORDS; i++)
      w.push_back(wr_word_rec.pop_front());
   push_beat({id, 8'h00, 8'hFF, a64 ? 8'h60 : 8'h40, 24'(2 * WR_WORDS)}, 1'b0, 1'b0);
   if (a64)
   begin
      push_beat({addr[31:0], addr[63:32]}, 1'b0, 1'b0);
      for (int i = 0; i < WR_WORDS; i++)
         push_beat({reverse_bytes(w[i][63:32]), reverse_bytes(w[i][31:0])}, 1'b0,
                   i == WR_WORDS - 1);
   end
   else
   begin
      push_beat({reverse_bytes(w[0][31:0]), addr[31:0]}, 1'b0, 1'b0);
      for (int i = 1; i < WR_WORDS; i++)   // halves shifted by one doubleword
         push_beat({reverse_bytes(w[i][31:0]), reverse_bytes(w[i-1][63:32])}, 1'b0, 1'b0);
      push_beat({32'h0, reverse_bytes(w[WR_WORDS-1][63:32])}, 1'b1, 1'b1);
   end
endfunction

`endif

/* tests/pcie_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_tx_tb;

   localparam int RD_LEN        = 32;
   localparam int WR_WORDS      = 4;
   localparam int total_packets = 47;
   localparam int cycle_limit   = 40 * total_packets + 200;

   `include "pcie_tx_model.svh"

   logic        clock;
   logic        reset;
   logic [15:0] pcie_id;
   logic [63:0] request_addr;
   logic        rc_valid;
   logic [23:0] rc_rid_tag;
   logic [3:0]  rc_lower_addr;
   logic [63:0] rc_data;
   logic        rc_ready;
   logic        rr_valid;
   logic [7:0]  rr_tag;
   logic        rr_ready;
   logic        wr_valid;
   logic [63:0] wr_data;
   logic        wr_ready;
   logic        tx_tready;
   logic [63:0] tx_tdata;
   logic        tx_1dw;
   logic        tx_tlast;
   logic        tx_tvalid;

   int seed = 32'h469a_65dd;
   int prob;                      // percent chance a source raises valid
   int rc_left;
   int rr_left;
   int wr_left;                   // write words still to offer
   int packets_done;
   int beats_seen;
   int planned_beats;
   int wr_hs_packet;              // write handshakes since the last write packet
   int cycles;
   logic hs_rc;
   logic hs_rr;
   logic hs_wr;
   logic started;
   logic saturated;
   logic stalled;
   logic [63:0] held_data;
   pcie_tx_pkg::tlp_kind_t prev_kind;
   logic [63:0] cap_data [$];
   logic        cap_1dw [$];
   logic        cap_last [$];

   pcie_tx_top #(.RD_LEN_DW(RD_LEN), .WR_WORDS(WR_WORDS)) DUT
   (
      .clock(clock), .reset(reset), .pcie_id(pcie_id), .request_addr(request_addr),
      .rc_valid(rc_valid), .rc_rid_tag(rc_rid_tag), .rc_lower_addr(rc_lower_addr),
      .rc_data(rc_data), .rc_ready(rc_ready),
      .rr_valid(rr_valid), .rr_tag(rr_tag), .rr_ready(rr_ready),
      .wr_valid(wr_valid), .wr_data(wr_data), .wr_ready(wr_ready),
      .tx_tready(tx_tready), .tx_tdata(tx_tdata), .tx_1dw(tx_1dw),
      .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid)
   );

   initial
   begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   function automatic logic chance(input int pct);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return (r % 100) < pct;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected)
      begin
         $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
         $display("CHECKS FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic fail_plain(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_packet();
      logic [7:0]             fmt;
      pcie_tx_pkg::tlp_kind_t kind;
      fmt = cap_data[0][31:24];
      exp_data.delete();
      exp_1dw.delete();
      exp_last.delete();
      if (fmt == pcie_tx_pkg::cpld_fmt)
      begin
         kind = pcie_tx_pkg::kind_rc;
         if (rc_tag_rec.size() == 0)
            fail_plain("a completion left the bus without a completion handshake");
         expect_rc(pcie_id);
      end
      else if (fmt == 8'h00 || fmt == 8'h20)
      begin
         kind = pcie_tx_pkg::kind_rr;
         if (rr_tag_rec.size() == 0)
            fail_plain("a read request left the bus without a read handshake");
         expect_rr(pcie_id, request_addr);
      end
      else if (fmt == 8'h40 || fmt == 8'h60)
      begin
         kind = pcie_tx_pkg::kind_wr;
         if (wr_word_rec.size() < WR_WORDS)
            fail_plain("a write left the bus with too few write handshakes");
         check_value("wr handshakes", 64'(wr_hs_packet), 64'(WR_WORDS));
         wr_hs_packet = 0;
         expect_wr(pcie_id, request_addr);
      end
      else
      begin
         kind = pcie_tx_pkg::kind_none;
         fail_plain("a packet started with an unknown format byte");
      end
      if (saturated && prev_kind == pcie_tx_pkg::kind_rc && kind == pcie_tx_pkg::kind_rc)
         fail_plain("two completions went out back to back while others waited");
      prev_kind = kind;
      check_value("packet beats", 64'(cap_data.size()), 64'(exp_data.size()));
      for (int i = 0; i < cap_data.size(); i++)
      begin
         check_value("tx_tdata", cap_data[i], exp_data[i]);
         check_value("tx_1dw", 64'(cap_1dw[i]), 64'(exp_1dw[i]));
         check_value("tx_tlast", 64'(cap_last[i]), 64'(exp_last[i]));
      end
      cap_data.delete();
      cap_1dw.delete();
      cap_last.delete();
      packets_done++;
   endtask

   // sources and back-pressure
   always @(posedge clock)
   begin
      if (!reset)
      begin
         tx_tready <= chance(70);
         if (!rc_valid || hs_rc)
         begin
            if (rc_left > 0 && chance(prob))
            begin
               rc_valid      <= 1'b1;
               rc_rid_tag    <= 24'($random(seed));
               rc_lower_addr <= 4'($random(seed));
               rc_data       <= {$random(seed), $random(seed)};
               rc_left = rc_left - 1;
            end
            else
               rc_valid <= 1'b0;
         end
         if (!rr_valid || hs_rr)
         begin
            if (rr_left > 0 && chance(prob))
            begin
               rr_valid <= 1'b1;
               rr_tag   <= 8'($random(seed));
               rr_left = rr_left - 1;
            end
            else
               rr_valid <= 1'b0;
         end
         if (!wr_valid || hs_wr)
         begin
            if (wr_left > 0 && chance(prob))
            begin
               wr_valid <= 1'b1;
               wr_data  <= {$random(seed), $random(seed)};
               wr_left = wr_left - 1;
            end
            else
               wr_valid <= 1'b0;
         end
      end
   end

   // monitor samples mid cycle where everything is settled
   always @(negedge clock)
   begin
      if (!reset)
      begin
         hs_rc = rc_valid && rc_ready;
         hs_rr = rr_valid && rr_ready;
         hs_wr = wr_valid && wr_ready;
         if (hs_rc)
         begin
            rc_tag_rec.push_back(rc_rid_tag);
            rc_la_rec.push_back(rc_lower_addr);
            rc_data_rec.push_back(rc_data);
         end
         if (hs_rr)
            rr_tag_rec.push_back(rr_tag);
         if (hs_wr)
         begin
            wr_word_rec.push_back(wr_data);
            wr_hs_packet++;
         end
         if (!started)
         begin
            if (rc_valid || rr_valid || wr_valid)
               started = 1'b1;
            else
            begin
               check_value("tx_tvalid", 64'(tx_tvalid), 64'h0);
               check_value("rc_ready", 64'(rc_ready), 64'h0);
               check_value("rr_ready", 64'(rr_ready), 64'h0);
               check_value("wr_ready", 64'(wr_ready), 64'h0);
            end
         end
         if (stalled)
            check_value("tx_tdata", tx_tdata, held_data);
         stalled   = tx_tvalid && !tx_tready;
         held_data = tx_tdata;
         if (tx_tvalid && tx_tready)
         begin
            cap_data.push_back(tx_tdata);
            cap_1dw.push_back(tx_1dw);
            cap_last.push_back(tx_tlast);
            beats_seen++;
            if (tx_tlast)
               check_packet();
         end
         cycles++;
         if (cycles >= cycle_limit)
            fail_plain("timeout: the planned packets did not all come out in time");
      end
   end

   task automatic run_phase(input logic [63:0] addr, input logic [15:0] id, input int nrc,
                            input int nrr, input int nwr, input int pct, input logic sat);
      int target;
      @(posedge clock);
      request_addr <= addr;
      pcie_id      <= id;
      @(negedge clock);   // counts settle away from the stimulus edge
      prev_kind = pcie_tx_pkg::kind_none;
      saturated = sat;
      prob      = pct;
      target    = packets_done + nrc + nrr + nwr;
      planned_beats = planned_beats + 3 * nrc + 2 * nrr + (WR_WORDS + 2) * nwr;
      rc_left = nrc;
      rr_left = nrr;
      wr_left = nwr * WR_WORDS;
      while (packets_done < target)
         @(posedge clock);
      @(negedge clock);
   endtask

   initial
   begin
      reset         = 1'b1;
      pcie_id       = 16'h0;
      request_addr  = 64'h0;
      rc_valid      = 1'b0;
      rc_rid_tag    = 24'h0;
      rc_lower_addr = 4'h0;
      rc_data       = 64'h0;
      rr_valid      = 1'b0;
      rr_tag        = 8'h0;
      wr_valid      = 1'b0;
      wr_data       = 64'h0;
      tx_tready     = 1'b0;
      {hs_rc, hs_rr, hs_wr, started, saturated, stalled} = 6'b0;
      {prob, rc_left, rr_left, wr_left} = {4{32'sd0}};
      {packets_done, beats_seen, planned_beats} = {3{32'sd0}};
      {wr_hs_packet, cycles} = {2{32'sd0}};
      held_data = 64'h0;
      prev_kind = pcie_tx_pkg::kind_none;
      repeat (3) @(posedge clock);
      reset <= 1'b0;
      repeat (5) @(negedge clock);   // quiet spell after reset
      run_phase({32'h0, $random(seed)}, 16'($random(seed)), 6, 6, 3, 40, 1'b0);
      run_phase({$random(seed) | 32'h1, $random(seed)}, 16'($random(seed)), 6, 6, 3, 40, 1'b0);
      run_phase({32'h0, $random(seed)}, 16'($random(seed)), 3, 3, 2, 100, 1'b1);
      run_phase({$random(seed) | 32'h1, $random(seed)}, 16'($random(seed)), 3, 4, 2, 100, 1'b1);
      check_value("beat count", 64'(beats_seen), 64'(planned_beats));
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* pcie_tx_top.f */
common/pcie_tx_pkg.sv
pcie_tx/pcie_tx_arbiter.sv
pcie_tx/pcie_tx_framer.sv
hw/pcie_tx_slice.sv
hw/pcie_tx_top.sv
+incdir+tests
tests/pcie_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pcie_tx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pcie_tx_top.f --top-module pcie_tx_tb -o sim_pcie_tx

./obj_dir/sim_pcie_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
exit 0
